//--- verilog.f
+incdir+test
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/inst_decoder.sv
verilog/exec_lane.sv
verilog/reg_file.sv
verilog/issue_stage.sv
verilog/dual_issue_core.sv
test/tb_dual_issue.sv

//--- Makefile
TOP := tb_dual_issue
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- test/tb_isa_model.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

// R-type function codes and I-type opcodes of the subset
localparam logic [5:0] R_FUNCTS [0:10] = '{6'h21, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27,
                                           6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03};
localparam logic [5:0] I_OPS [0:5] = '{6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};

// op[31:26] rs[25:21] rt[20:16] rd[15:11] sh[10:6] fn[5:0]
function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sh);
    return {6'h00, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic is_defined(input logic [31:0] w);
    if (w[31:26] == 6'h00) begin
        return w[5:0] inside {6'h00, 6'h02, 6'h03, 6'h21, 6'h23, 6'h24, 6'h25, 6'h26,
                              6'h27, 6'h2a, 6'h2b};
    end
    return w[31:26] inside {6'h09, 6'h0a, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
endfunction

function automatic logic [4:0] dest_of(input logic [31:0] w);
    return (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
endfunction

function automatic logic writes(input logic [31:0] w);
    return is_defined(w) && (dest_of(w) != 5'd0);
endfunction

// does w use register r as a source
function automatic logic reads(input logic [31:0] w, input logic [4:0] r);
    logic shift;
    shift = (w[31:26] == 6'h00) && (w[5:0] inside {6'h00, 6'h02, 6'h03});
    if (!is_defined(w)) begin
        return 1'b0;
    end
    if (w[31:26] == 6'h00) begin
        return (w[20:16] == r) || (!shift && (w[25:21] == r));
    end
    // LUI has no source register
    return (w[31:26] != 6'h0f) && (w[25:21] == r);
endfunction

// a is the value of rs, b the value of rt
function automatic logic [31:0] model_alu(input logic [31:0] w, input logic [31:0] a,
                                          input logic [31:0] b);
    logic [31:0] sx;
    logic [31:0] zx;
    logic [4:0]  sh;
    sx = {{16{w[15]}}, w[15:0]};
    zx = {16'h0000, w[15:0]};
    sh = w[10:6];
    if (w[31:26] == 6'h00) begin
        case (w[5:0])
            6'h21:   return a + b;
            6'h23:   return a - b;
            6'h24:   return a & b;
            6'h25:   return a | b;
            6'h26:   return a ^ b;
            6'h27:   return ~(a | b);
            6'h2a:   return {31'd0, $signed(a) < $signed(b)};
            6'h2b:   return {31'd0, a < b};
            6'h00:   return b << sh;
            6'h02:   return b >> sh;
            6'h03:   return $unsigned($signed(b) >>> sh);
            default: return 32'd0;
        endcase
    end
    case (w[31:26])
        6'h09:   return a + sx;
        6'h0a:   return {31'd0, $signed(a) < $signed(sx)};
        6'h0c:   return a & zx;
        6'h0d:   return a | zx;
        6'h0e:   return a ^ zx;
        6'h0f:   return {w[15:0], 16'h0000};
        default: return 32'd0;
    endcase
endfunction

// slots accepted for one offer
function automatic logic [1:0] pair_take(input logic v0, input logic [31:0] w0,
                                         input logic v1, input logic [31:0] w1);
    if (!v0) begin
        return 2'd0;
    end
    if (v1 && !(writes(w0) && reads(w1, dest_of(w0)))) begin
        return 2'd2;
    end
    return 2'd1;
endfunction

`endif

//--- test/tb_dual_issue.sv
`timescale 1ns/10ps

module tb_dual_issue;
    import core_pkg::*;

    `include "tb_isa_model.svh"

    localparam int PROG_LEN    = 300;
    localparam int PREFIX_LEN  = 16;
    localparam int CYCLE_LIMIT = (PROG_LEN + 20) * 2;

    logic              clk = 1'b0;
    logic              arst_n;
    fetch_slot_t [1:0] fetch_slots;
    logic [1:0]        fetch_take;
    lane_result_t      commit_master;
    lane_result_t      commit_slave;

    logic [31:0]  prog [PROG_LEN];
    lane_result_t exp_q [$];
    int           exp_idx [$];
    int           head;
    int           cycles = 0;
    int           checks;
    int           value_errors;
    int           other_errors;
    logic [1:0]   take_seen;

    dual_issue_core DUT (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .fetch_slots   ( fetch_slots   ),
        .fetch_take    ( fetch_take    ),
        .commit_master ( commit_master ),
        .commit_slave  ( commit_slave  )
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] lcg(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] sel;
        r = 32'h6e43_cda4;
        // chained r1 updates, then r0 writes and undefined words, then a same-dest pair
        prog[0]  = enc_i(6'h09, 5'd0, 5'd1, 16'd5);
        prog[1]  = enc_i(6'h09, 5'd1, 5'd1, 16'd3);
        prog[2]  = enc_r(6'h21, 5'd1, 5'd1, 5'd1, 5'd0);
        prog[3]  = enc_i(6'h09, 5'd1, 5'd1, 16'hffff);
        prog[4]  = enc_r(6'h21, 5'd1, 5'd1, 5'd2, 5'd0);
        prog[5]  = enc_r(6'h21, 5'd2, 5'd1, 5'd3, 5'd0);
        prog[6]  = enc_i(6'h09, 5'd1, 5'd0, 16'd9);
        prog[7]  = 32'hffff_ffff;
        prog[8]  = enc_r(6'h3f, 5'd1, 5'd1, 5'd4, 5'd0);
        prog[9]  = enc_r(6'h21, 5'd0, 5'd3, 5'd4, 5'd0);
        // reads r4 so it always lands in slot 0 and pairs with the next one
        prog[10] = enc_i(6'h09, 5'd4, 5'd5, 16'd11);
        prog[11] = enc_i(6'h09, 5'd0, 5'd5, 16'd22);
        prog[12] = enc_r(6'h21, 5'd5, 5'd0, 5'd6, 5'd0);
        prog[13] = enc_i(6'h0f, 5'd0, 5'd7, 16'h8765);
        prog[14] = enc_i(6'h0d, 5'd7, 5'd7, 16'h4321);
        prog[15] = enc_r(6'h03, 5'd0, 5'd7, 5'd6, 5'd4);
        for (int i = PREFIX_LEN; i < PROG_LEN; i++) begin
            r = lcg(r);
            sel = r;
            r = lcg(r);
            if (sel[31:24] < 8'd13) begin
                // unused primary opcode or unused SPECIAL function
                prog[i] = sel[20] ? {6'h3f, r[25:0]} : {6'h00, r[25:6], 6'h3f};
            end else if (sel[23]) begin
                prog[i] = enc_i(I_OPS[int'(sel[18:16]) % 6], {2'b00, r[31:29]},
                                {2'b00, r[28:26]}, r[25:10]);
            end else begin
                prog[i] = enc_r(R_FUNCTS[int'(sel[19:16]) % 11], {2'b00, r[31:29]},
                                {2'b00, r[28:26]}, {2'b00, r[25:23]}, r[22:18]);
            end
        end
    endtask

    // in-order execution with one record per writing instruction
    task automatic run_model();
        logic [31:0]  regs [32];
        lane_result_t rec;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            if (writes(prog[i])) begin
                rec.wen  = 1'b1;
                rec.dest = dest_of(prog[i]);
                rec.data = model_alu(prog[i], regs[prog[i][25:21]], regs[prog[i][20:16]]);
                regs[rec.dest] = rec.data;
                exp_q.push_back(rec);
                exp_idx.push_back(i);
            end
        end
    endtask

    task automatic drive_slots();
        fetch_slots[0].valid = (head < PROG_LEN);
        fetch_slots[0].instr = (head < PROG_LEN) ? prog[head] : 32'd0;
        fetch_slots[1].valid = (head + 1 < PROG_LEN);
        fetch_slots[1].instr = (head + 1 < PROG_LEN) ? prog[head + 1] : 32'd0;
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("ERROR %s: %s expected %h, got %h", test, what, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_commit(input string lane, input lane_result_t c);
        lane_result_t e;
        int           idx;
        string        test;
        if (c.wen) begin
            checks++;
            assert (exp_q.size() > 0 && c.dest != 5'd0) else begin
                $display("unexpected %s commit to register %0d", lane, c.dest);
                other_errors++;
            end
            if (exp_q.size() > 0) begin
                e = exp_q.pop_front();
                idx = exp_idx.pop_front();
                test = (idx < PREFIX_LEN) ? "directed" : "random";
                check_value(test, $sformatf("instr %0d %s dest", idx, lane),
                            32'(e.dest), 32'(c.dest));
                check_value(test, $sformatf("instr %0d %s data", idx, lane), e.data, c.data);
            end
        end
    endtask

    task automatic print_summary(input int extra);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors + extra);
    endtask

    // run length bounded by program size
    always @(posedge clk) begin
        if (arst_n) begin
            cycles = cycles + 1;
            if (cycles >= CYCLE_LIMIT) begin
                $display("timeout after %0d cycles, %0d results never committed",
                         cycles, exp_q.size());
                print_summary(1);
                $display("test failed");
                $finish;
            end
        end
    end

    initial begin
        arst_n = 1'b0;
        fetch_slots = '0;
        head = 0;
        checks = 0;
        value_errors = 0;
        other_errors = 0;
        take_seen = 2'd0;
        build_program();
        run_model();
        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // idle after reset with nothing offered
        repeat (2) begin
            @(negedge clk);
            check_value("reset_idle", "fetch_take", 32'd0, 32'(fetch_take));
            check_value("reset_idle", "master wen", 32'd0, 32'(commit_master.wen));
            check_value("reset_idle", "slave wen", 32'd0, 32'(commit_slave.wen));
        end

        @(posedge clk);
        #1;
        drive_slots();
        while (head < PROG_LEN || exp_q.size() > 0) begin
            @(negedge clk);
            check_value("pairing", $sformatf("fetch_take at instr %0d", head),
                        32'(pair_take(fetch_slots[0].valid, fetch_slots[0].instr,
                                      fetch_slots[1].valid, fetch_slots[1].instr)),
                        32'(fetch_take));
            check_commit("master", commit_master);
            check_commit("slave", commit_slave);
            take_seen = fetch_take;
            @(posedge clk);
            #1;
            head = head + int'(take_seen);
            drive_slots();
        end

        // once drained any further commit is spurious
        repeat (3) begin
            @(negedge clk);
            check_commit("master", commit_master);
            check_commit("slave", commit_slave);
        end

        print_summary(0);
        if (value_errors + other_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- verilog/dual_issue_core.sv
`timescale 1ns/10ps

module dual_issue_core (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::fetch_slot_t [1:0] fetch_slots,
    output logic [1:0]                  fetch_take,
    output core_pkg::lane_result_t      commit_master,
    output core_pkg::lane_result_t      commit_slave
);
    import core_pkg::*;

    reg_read_t [1:0]  rf_read;
    logic [3:0][31:0] rf_data;
    exec_req_t        req_master;
    exec_req_t        req_slave;
    lane_result_t     e_master;
    lane_result_t     e_slave;
    lane_result_t     w_master;
    lane_result_t     w_slave;

    issue_stage u_issue (
        .clk         ( clk         ),
        .arst_n      ( arst_n      ),
        .fetch_slots ( fetch_slots ),
        .fetch_take  ( fetch_take  ),
        .rf_read     ( rf_read     ),
        .rf_data     ( rf_data     ),
        .e_master    ( e_master    ),
        .e_slave     ( e_slave     ),
        .w_master    ( w_master    ),
        .w_slave     ( w_slave     ),
        .req_master  ( req_master  ),
        .req_slave   ( req_slave   )
    );

    exec_lane u_master (
        .clk      ( clk        ),
        .arst_n   ( arst_n     ),
        .req      ( req_master ),
        .e_result ( e_master   ),
        .w_result ( w_master   )
    );

    exec_lane u_slave (
        .clk      ( clk       ),
        .arst_n   ( arst_n    ),
        .req      ( req_slave ),
        .e_result ( e_slave   ),
        .w_result ( w_slave   )
    );

    reg_file u_reg_file (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .rf_read  ( rf_read  ),
        .rf_data  ( rf_data  ),
        .w_master ( w_master ),
        .w_slave  ( w_slave  )
    );

    // commit shows the writeback registers
    assign commit_master = w_master;
    assign commit_slave  = w_slave;

endmodule

//--- verilog/issue_stage.sv
`timescale 1ns/10ps

module issue_stage (
    input  logic                        clk,
    input  logic                        arst_n,
    input  core_pkg::fetch_slot_t [1:0] fetch_slots,
    output logic [1:0]                  fetch_take,
    output core_pkg::reg_read_t [1:0]   rf_read,
    input  logic [3:0][31:0]            rf_data,
    input  core_pkg::lane_result_t      e_master,
    input  core_pkg::lane_result_t      e_slave,
    input  core_pkg::lane_result_t      w_master,
    input  core_pkg::lane_result_t      w_slave,
    output core_pkg::exec_req_t         req_master,
    output core_pkg::exec_req_t         req_slave
);
    import isa_pkg::*;
    import core_pkg::*;

    decoded_t    dec_m;
    decoded_t    dec_s;
    logic        slave_dep;
    logic        take_m;
    logic        take_s;
    logic [31:0] m_rs_val;
    logic [31:0] m_rt_val;
    logic [31:0] s_rs_val;
    logic [31:0] s_rt_val;

    function automatic logic hit(input lane_result_t res, input logic [4:0] idx);
        return res.wen && (res.dest == idx) && (idx != 5'd0);
    endfunction

    // youngest producer first: E slave, E master, W slave, W master, then rf
    function automatic logic [31:0] operand(
        input logic [4:0]   idx,
        input logic [31:0]  rf_val,
        input lane_result_t es,
        input lane_result_t em,
        input lane_result_t ws,
        input lane_result_t wm
    );
        if (hit(es, idx)) return es.data;
        if (hit(em, idx)) return em.data;
        if (hit(ws, idx)) return ws.data;
        if (hit(wm, idx)) return wm.data;
        return rf_val;
    endfunction

    function automatic exec_req_t build_req(
        input logic        take,
        input decoded_t    dec,
        input logic [31:0] rs_val,
        input logic [31:0] rt_val
    );
        exec_req_t req;
        req.valid   = take;
        req.alu_op  = dec.alu_op;
        req.a       = rs_val;
        req.b       = dec.use_imm ? dec.imm_value : rt_val;
        req.shamt   = dec.shamt;
        req.dest    = dec.dest;
        req.reg_wen = take & dec.reg_wen;
        return req;
    endfunction

    inst_decoder u_dec_master (
        .instr ( fetch_slots[0].instr ),
        .dec   ( dec_m                )
    );

    inst_decoder u_dec_slave (
        .instr ( fetch_slots[1].instr ),
        .dec   ( dec_s                )
    );

    // slave cannot pair when it reads what the master writes
    assign slave_dep = dec_m.reg_wen &&
                       ((dec_s.uses_rs && (dec_s.rs == dec_m.dest)) ||
                        (dec_s.uses_rt && (dec_s.rt == dec_m.dest)));

    assign take_m     = fetch_slots[0].valid;
    assign take_s     = take_m && fetch_slots[1].valid && !slave_dep;
    assign fetch_take = {take_s, take_m & ~take_s};

    assign rf_read[0] = '{rs: dec_m.rs, rt: dec_m.rt};
    assign rf_read[1] = '{rs: dec_s.rs, rt: dec_s.rt};

    assign m_rs_val = operand(dec_m.rs, rf_data[0], e_slave, e_master, w_slave, w_master);
    assign m_rt_val = operand(dec_m.rt, rf_data[1], e_slave, e_master, w_slave, w_master);
    assign s_rs_val = operand(dec_s.rs, rf_data[2], e_slave, e_master, w_slave, w_master);
    assign s_rt_val = operand(dec_s.rt, rf_data[3], e_slave, e_master, w_slave, w_master);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_master <= '0;
            req_slave  <= '0;
        end else begin
            req_master <= build_req(take_m, dec_m, m_rs_val, m_rt_val);
            req_slave  <= build_req(take_s, dec_s, s_rs_val, s_rt_val);
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic                      clk,
    input  logic                      arst_n,
    input  core_pkg::reg_read_t [1:0] rf_read,
    output logic [3:0][31:0]          rf_data,
    input  core_pkg::lane_result_t    w_master,
    input  core_pkg::lane_result_t    w_slave
);

    // register 0 has no storage
    logic [31:0] regs [1:31];

    // port order: master rs, master rt, slave rs, slave rt
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            rf_data[2*p]   = (rf_read[p].rs == 5'd0) ? 32'd0 : regs[rf_read[p].rs];
            rf_data[2*p+1] = (rf_read[p].rt == 5'd0) ? 32'd0 : regs[rf_read[p].rt];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            if (w_master.wen && (w_master.dest != 5'd0)) begin
                regs[w_master.dest] <= w_master.data;
            end
            // slave is the younger one, its write lands last
            if (w_slave.wen && (w_slave.dest != 5'd0)) begin
                regs[w_slave.dest] <= w_slave.data;
            end
        end
    end

endmodule

//--- verilog/exec_lane.sv
`timescale 1ns/10ps

module exec_lane (
    input  logic                   clk,
    input  logic                   arst_n,
    input  core_pkg::exec_req_t    req,
    output core_pkg::lane_result_t e_result,
    output core_pkg::lane_result_t w_result
);
    import isa_pkg::*;

    logic [31:0] alu_y;

    always_comb begin
        case (req.alu_op)
            ALU_ADD:  alu_y = req.a + req.b;
            ALU_SUB:  alu_y = req.a - req.b;
            ALU_AND:  alu_y = req.a & req.b;
            ALU_OR:   alu_y = req.a | req.b;
            ALU_XOR:  alu_y = req.a ^ req.b;
            ALU_NOR:  alu_y = ~(req.a | req.b);
            ALU_SLT:  alu_y = {31'd0, $signed(req.a) < $signed(req.b)};
            ALU_SLTU: alu_y = {31'd0, req.a < req.b};
            // shifts work on rt, amount from the shamt field
            ALU_SLL:  alu_y = req.b << req.shamt;
            ALU_SRL:  alu_y = req.b >> req.shamt;
            ALU_SRA:  alu_y = $unsigned($signed(req.b) >>> req.shamt);
            ALU_LUI:  alu_y = {req.b[15:0], 16'h0000};
            default:  alu_y = 32'd0;
        endcase
    end

    // E-stage result feeds the forwarding network in issue
    assign e_result = '{
        wen:  req.valid & req.reg_wen,
        dest: req.dest,
        data: alu_y
    };

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            w_result <= '0;
        end else begin
            w_result <= e_result;
        end
    end

endmodule

//--- verilog/inst_decoder.sv
`timescale 1ns/10ps

module inst_decoder (
    input  logic [31:0]       instr,
    output isa_pkg::decoded_t dec
);
    import isa_pkg::*;

    logic [31:0] sext_imm;
    logic [31:0] zext_imm;
    logic        imm_form;
    logic        defined;

    assign sext_imm = {{16{instr[15]}}, instr[15:0]};
    assign zext_imm = {16'h0000, instr[15:0]};

    always_comb begin
        dec           = '0;
        dec.alu_op    = ALU_NONE;
        dec.rs        = instr[25:21];
        dec.rt        = instr[20:16];
        dec.shamt     = instr[10:6];
        dec.dest      = instr[15:11];
        imm_form      = 1'b1;
        defined       = 1'b1;

        case (opcode_e'(instr[31:26]))
            OP_SPECIAL: begin
                imm_form    = 1'b0;
                dec.uses_rs = 1'b1;
                dec.uses_rt = 1'b1;
                case (funct_e'(instr[5:0]))
                    FN_ADDU: dec.alu_op = ALU_ADD;
                    FN_SUBU: dec.alu_op = ALU_SUB;
                    FN_AND:  dec.alu_op = ALU_AND;
                    FN_OR:   dec.alu_op = ALU_OR;
                    FN_XOR:  dec.alu_op = ALU_XOR;
                    FN_NOR:  dec.alu_op = ALU_NOR;
                    FN_SLT:  dec.alu_op = ALU_SLT;
                    FN_SLTU: dec.alu_op = ALU_SLTU;
                    FN_SLL:  dec.alu_op = ALU_SLL;
                    FN_SRL:  dec.alu_op = ALU_SRL;
                    FN_SRA:  dec.alu_op = ALU_SRA;
                    default: defined    = 1'b0;
                endcase
                // shifts take rt only, the amount comes from shamt
                if (dec.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) begin
                    dec.uses_rs = 1'b0;
                end
            end
            OP_ADDIU: begin
                dec.alu_op    = ALU_ADD;
                dec.imm_value = sext_imm;
            end
            OP_SLTI: begin
                dec.alu_op    = ALU_SLT;
                dec.imm_value = sext_imm;
            end
            OP_ANDI: begin
                dec.alu_op    = ALU_AND;
                dec.imm_value = zext_imm;
            end
            OP_ORI: begin
                dec.alu_op    = ALU_OR;
                dec.imm_value = zext_imm;
            end
            OP_XORI: begin
                dec.alu_op    = ALU_XOR;
                dec.imm_value = zext_imm;
            end
            OP_LUI: begin
                dec.alu_op    = ALU_LUI;
                dec.imm_value = zext_imm;
            end
            default: defined = 1'b0;
        endcase

        // I-type writes rt and reads rs (LUI reads nothing)
        if (imm_form) begin
            dec.dest    = instr[20:16];
            dec.use_imm = 1'b1;
            dec.uses_rs = (dec.alu_op != ALU_LUI);
        end

        if (!defined) begin
            dec.alu_op  = ALU_NONE;
            dec.uses_rs = 1'b0;
            dec.uses_rt = 1'b0;
        end
        dec.reg_wen = defined && (dec.dest != 5'd0);
    end

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    // one instruction offered by the fetch side
    typedef struct packed {
        logic        valid;
        logic [31:0] instr;
    } fetch_slot_t;

    // register indices read by one slot
    typedef struct packed {
        logic [4:0] rs;
        logic [4:0] rt;
    } reg_read_t;

    // everything a lane needs in execute
    typedef struct packed {
        logic               valid;
        isa_pkg::alu_op_e   alu_op;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [4:0]         shamt;
        logic [4:0]         dest;
        logic               reg_wen;
    } exec_req_t;

    // result of one lane in E or W, used for forwarding and commit
    typedef struct packed {
        logic        wen;
        logic [4:0]  dest;
        logic [31:0] data;
    } lane_result_t;

endpackage

//--- verilog/isa_pkg.sv
package isa_pkg;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f
    } opcode_e;

    // function field of SPECIAL words, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a,
        FN_SLTU = 6'h2b
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI,
        ALU_NONE
    } alu_op_e;

    typedef struct packed {
        alu_op_e     alu_op;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic        uses_rs;
        logic        uses_rt;
        logic [4:0]  dest;
        // low for undefined words and for dest 0
        logic        reg_wen;
        logic        use_imm;
        logic [31:0] imm_value;
        logic [4:0]  shamt;
    } decoded_t;

endpackage
